// File: source/hi_rx_pkg.sv
/*
 * Shared constants for the 13.56 MHz receive path.
 * The accumulator widths assume 8-bit unsigned ADC samples and 64-sample windows.
 */

`default_nettype none

package hi_rx_pkg;

    // ----------------------------------------
    // Sample path
    // ----------------------------------------
    localparam int adc_w          = 8;
    localparam int accum_w        = 16;
    localparam int window_len     = 64;
    localparam int window_cnt_w   = 6;

    // The quadrature reference leads the in-phase one by a quarter cycle.
    localparam int q_phase_offset = 4;

    // This window counter bit is the reference sign. One means subtract.
    localparam int ref_half_bit   = 3;

    // The slice of the accumulators that is reported in reader mode.
    localparam int out_msb        = 13;
    localparam int out_lsb        = 6;

    // ----------------------------------------
    // Serial port and configuration
    // ----------------------------------------
    localparam int report_w        = 16;
    localparam int samples_per_bit = 4;
    localparam int spb_w           = $clog2(samples_per_bit);
    localparam int word_cnt_w      = $clog2(report_w * samples_per_bit);

    localparam int cfg_w          = 2;
    localparam int cfg_bit_848    = 0;
    localparam int cfg_bit_snoop  = 1;

    // Snoop-mode envelope detector.
    localparam int hyst_timeout   = 4095;
    localparam int hyst_cnt_w     = 12;

endpackage

`default_nettype wire

// File: source/rx_mode_regs.sv
/*
 * Mode register written through a four-phase req/ack handshake.
 * cfg_req must come from the ck_1356meg domain, and cfg_data must hold while it is high.
 */

`timescale 1ns/100ps
`default_nettype none

module rx_mode_regs
    import hi_rx_pkg::*;
(
    input  wire logic             ck_1356meg,
    input  wire logic             rst_n,
    input  wire logic             cfg_req,
    input  wire logic [cfg_w-1:0] cfg_data,
    output logic                  cfg_ack,
    output logic                  mode_848,
    output logic                  snoop,
    output logic                  carrier_on,
    output logic                  sample_en,
    output logic                  sample_restart
);

    // Phase of the divide-by-two used in 424 kHz mode.
    logic div_phase;

    // ----------------------------------------
    // Handshake and mode latch
    // ----------------------------------------
    // A write is taken on the first edge that sees cfg_req high while
    // cfg_ack is still low. The acknowledge then stays up until the host
    // drops its request, which closes the four-phase cycle.
    always_ff @(posedge ck_1356meg)
    begin
        if (!rst_n)
        begin
            cfg_ack        <= 1'b0;
            mode_848       <= 1'b0;
            snoop          <= 1'b0;
            sample_restart <= 1'b0;
        end
        else
        begin
            // The restart strobe lasts for one cycle only.
            sample_restart <= 1'b0;
            if (cfg_req && !cfg_ack)
            begin
                cfg_ack        <= 1'b1;
                mode_848       <= cfg_data[cfg_bit_848];
                snoop          <= cfg_data[cfg_bit_snoop];
                sample_restart <= 1'b1;
            end
            else if (!cfg_req && cfg_ack)
            begin
                cfg_ack <= 1'b0;
            end
        end
    end

    // The carrier is switched off while snooping so that only the
    // external reader's field reaches the antenna.
    always_ff @(posedge ck_1356meg)
    begin
        if (!rst_n)
        begin
            carrier_on <= 1'b1;
        end
        else
        begin
            carrier_on <= ~snoop;
        end
    end

    // ----------------------------------------
    // Sample strobe
    // ----------------------------------------
    // The phase starts at one so that the first edge after reset, and
    // the first edge after a write, both take a sample.
    always_ff @(posedge ck_1356meg)
    begin
        if (!rst_n)
        begin
            div_phase <= 1'b1;
        end
        else if (cfg_req && !cfg_ack)
        begin
            div_phase <= 1'b1;
        end
        else
        begin
            div_phase <= ~div_phase;
        end
    end

    // In 848 kHz mode every clock is a sample. Otherwise every second one.
    assign sample_en = mode_848 | div_phase;

endmodule

`default_nettype wire

// File: source/am_hysteresis.sv
/*
 * Envelope detector used to recover reader commands in snoop mode.
 * Only full-scale samples move the level, and a long low time forces it high.
 */

`timescale 1ns/100ps
`default_nettype none

module am_hysteresis
    import hi_rx_pkg::*;
(
    input  wire logic             ck_1356meg,
    input  wire logic             rst_n,
    input  wire logic             sample_en,
    input  wire logic [adc_w-1:0] adc_d,
    output logic                  env_now
);

    // Number of samples the level has spent low.
    logic [hyst_cnt_w-1:0] low_cnt;

    // ----------------------------------------
    // Level and low-time counter
    // ----------------------------------------
    // An all-ones sample sets the level and an all-zeros sample clears it.
    // Anything between the two rails keeps the previous level, which is
    // the hysteresis. A level that stays low for a whole counter period
    // is taken as a lost field and forced back high, so the detector
    // cannot stick low when the reader goes quiet.
    always_ff @(posedge ck_1356meg)
    begin
        if (!rst_n)
        begin
            env_now <= 1'b0;
            low_cnt <= '0;
        end
        else if (sample_en)
        begin
            if (&adc_d)
            begin
                env_now <= 1'b1;
            end
            else if (~|adc_d)
            begin
                env_now <= 1'b0;
            end

            if (env_now)
            begin
                low_cnt <= '0;
            end
            else if (low_cnt == hyst_cnt_w'(hyst_timeout))
            begin
                // The timeout wins over a low sample on the same edge.
                low_cnt <= '0;
                env_now <= 1'b1;
            end
            else
            begin
                low_cnt <= low_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/iq_correlator.sv
/*
 * I/Q correlator over 64-sample windows against a square-wave subcarrier.
 * Samples are unsigned. report is updated and report_load pulses one edge after sample 63.
 * sample_restart must coincide with a sample strobe and starts a new window at once.
 */

`timescale 1ns/100ps
`default_nettype none

module iq_correlator
    import hi_rx_pkg::*;
(
    input  wire logic                ck_1356meg,
    input  wire logic                rst_n,
    input  wire logic                sample_en,
    input  wire logic                sample_restart,
    input  wire logic                snoop,
    input  wire logic [adc_w-1:0]    adc_d,
    input  wire logic                env_now,
    output logic      [report_w-1:0] report,
    output logic                     report_load
);

    localparam logic [window_cnt_w-1:0] last_idx = window_cnt_w'(window_len - 1);
    localparam logic [window_cnt_w-1:0] mid_idx  = window_cnt_w'(window_len / 2 - 1);

    // Window position of the sample on this edge, and its Q reference index.
    logic [window_cnt_w-1:0] win_cnt;
    logic [window_cnt_w-1:0] n_now;
    logic [window_cnt_w-1:0] q_idx;

    logic signed [accum_w-1:0] acc_i;
    logic signed [accum_w-1:0] acc_q;
    logic signed [accum_w-1:0] base_i;
    logic signed [accum_w-1:0] base_q;
    logic signed [accum_w-1:0] adc_ext;

    // Detector bits captured at mid-window and at the last sample.
    logic env_mid;
    logic env_last;
    logic window_done;

    logic [7:0] i_byte;
    logic [7:0] q_byte;

    // ----------------------------------------
    // Reference generation
    // ----------------------------------------
    // A restart makes the current sample the first one of a window.
    assign n_now = sample_restart ? '0 : win_cnt;
    // The Q index wraps modulo the window length by its width.
    assign q_idx = n_now + window_cnt_w'(q_phase_offset);

    // Zero extension keeps the sample positive in the signed sum.
    assign adc_ext = $signed({{(accum_w - adc_w){1'b0}}, adc_d});

    // Sample 0 starts from zero instead of the previous total.
    assign base_i = (n_now == '0) ? '0 : acc_i;
    assign base_q = (n_now == '0) ? '0 : acc_q;

    // ----------------------------------------
    // Accumulators and window counter
    // ----------------------------------------
    always_ff @(posedge ck_1356meg)
    begin
        if (sample_en)
        begin
            acc_i <= n_now[ref_half_bit] ? base_i - adc_ext : base_i + adc_ext;
            acc_q <= q_idx[ref_half_bit] ? base_q - adc_ext : base_q + adc_ext;
            if (n_now == mid_idx)
            begin
                env_mid <= env_now;
            end
            if (n_now == last_idx)
            begin
                env_last <= env_now;
            end
        end
    end

    always_ff @(posedge ck_1356meg)
    begin
        if (!rst_n)
        begin
            win_cnt     <= '0;
            window_done <= 1'b0;
        end
        else
        begin
            window_done <= sample_en && (n_now == last_idx);
            if (sample_en)
            begin
                win_cnt <= n_now + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Output formatting
    // ----------------------------------------
    // In snoop mode the low bit of each byte carries a detector sample, at
    // the cost of one bit of correlation range.
    always_comb
    begin
        if (snoop)
        begin
            i_byte = {acc_i[out_msb-1:out_lsb], env_mid};
            q_byte = {acc_q[out_msb-1:out_lsb], env_last};
        end
        else
        begin
            i_byte = acc_i[out_msb:out_lsb];
            q_byte = acc_q[out_msb:out_lsb];
        end
    end

    always_ff @(posedge ck_1356meg)
    begin
        if (window_done)
        begin
            report <= {i_byte, q_byte};
        end
    end

    always_ff @(posedge ck_1356meg)
    begin
        if (!rst_n)
        begin
            report_load <= 1'b0;
        end
        else
        begin
            report_load <= window_done;
        end
    end

endmodule

`default_nettype wire

// File: source/ssp_serializer.sv
/*
 * Serial port transmitter, MSB first, four samples per bit.
 * There is no flow control. A new report_load cuts off any word still in flight.
 */

`timescale 1ns/100ps
`default_nettype none

module ssp_serializer
    import hi_rx_pkg::*;
(
    input  wire logic                ck_1356meg,
    input  wire logic                rst_n,
    input  wire logic                sample_en,
    input  wire logic                report_load,
    input  wire logic [report_w-1:0] report,
    output logic                     ssp_clk,
    output logic                     ssp_frame,
    output logic                     ssp_din
);

    localparam logic [word_cnt_w-1:0] last_pos = word_cnt_w'(report_w * samples_per_bit - 1);

    // Upper bits of pos give the bit number, lower bits the sample in it.
    logic [word_cnt_w-1:0] pos;
    logic [word_cnt_w-1:0] pos_inc;
    logic [report_w-1:0]   shift_reg;
    logic                  active;

    assign pos_inc = pos + 1'b1;

    // ----------------------------------------
    // Shift and clock generation
    // ----------------------------------------
    // The load edge shows bit 15 with the clock low and the frame high.
    // Each later sample advances the position. The clock is high in the
    // second half of a bit so the host can sample in the middle.
    always_ff @(posedge ck_1356meg)
    begin
        if (!rst_n)
        begin
            active    <= 1'b0;
            pos       <= '0;
            ssp_clk   <= 1'b0;
            ssp_frame <= 1'b0;
            ssp_din   <= 1'b0;
        end
        else if (report_load)
        begin
            active    <= 1'b1;
            pos       <= '0;
            ssp_clk   <= 1'b0;
            ssp_frame <= 1'b1;
            ssp_din   <= report[report_w-1];
        end
        else if (sample_en && active)
        begin
            pos <= pos_inc;
            if (pos == last_pos)
            begin
                // The word is over and no new one arrived. Go idle.
                active    <= 1'b0;
                ssp_clk   <= 1'b0;
                ssp_frame <= 1'b0;
                ssp_din   <= 1'b0;
            end
            else
            begin
                ssp_clk   <= pos_inc[spb_w-1];
                ssp_frame <= (pos_inc[word_cnt_w-1:spb_w] == '0);
                if (pos_inc[spb_w-1:0] == '0)
                begin
                    ssp_din <= shift_reg[report_w-2];
                end
            end
        end
    end

    // The data register has no reset. ssp_din covers the idle level.
    always_ff @(posedge ck_1356meg)
    begin
        if (report_load)
        begin
            shift_reg <= report;
        end
        else if (sample_en && active && pos_inc[spb_w-1:0] == '0)
        begin
            shift_reg <= {shift_reg[report_w-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: source/hi_read_rx_xcorr.sv
/*
 * Receive path top level. Everything runs on ck_1356meg.
 * ADC clock generation and carrier drive are outside. Only carrier_on is exported.
 * ssp_frame rises two cycles after the edge that takes the last sample of a window.
 */

`timescale 1ns/100ps
`default_nettype none

module hi_read_rx_xcorr
    import hi_rx_pkg::*;
(
    input  wire logic             ck_1356meg,
    input  wire logic             rst_n,
    input  wire logic [adc_w-1:0] adc_d,
    input  wire logic             cfg_req,
    input  wire logic [cfg_w-1:0] cfg_data,
    output logic                  cfg_ack,
    output logic                  carrier_on,
    output logic                  ssp_clk,
    output logic                  ssp_frame,
    output logic                  ssp_din
);

    // ----------------------------------------
    // Internal nets
    // ----------------------------------------
    logic                snoop;
    logic                sample_en;
    logic                sample_restart;
    logic                env_now;
    logic [report_w-1:0] report;
    logic                report_load;

    // Mode register and sample strobe.
    // The 848 kHz flag only shapes the sample strobe inside the mode block.
    rx_mode_regs u_rx_mode_regs (
        .ck_1356meg     (ck_1356meg),
        .rst_n          (rst_n),
        .cfg_req        (cfg_req),
        .cfg_data       (cfg_data),
        .cfg_ack        (cfg_ack),
        .mode_848       (),
        .snoop          (snoop),
        .carrier_on     (carrier_on),
        .sample_en      (sample_en),
        .sample_restart (sample_restart)
    );

    // The detector runs all the time. Its output matters only in snoop mode.
    am_hysteresis u_am_hysteresis (
        .ck_1356meg (ck_1356meg),
        .rst_n      (rst_n),
        .sample_en  (sample_en),
        .adc_d      (adc_d),
        .env_now    (env_now)
    );

    iq_correlator u_iq_correlator (
        .ck_1356meg     (ck_1356meg),
        .rst_n          (rst_n),
        .sample_en      (sample_en),
        .sample_restart (sample_restart),
        .snoop          (snoop),
        .adc_d          (adc_d),
        .env_now        (env_now),
        .report         (report),
        .report_load    (report_load)
    );

    // One word per window leaves on the serial port.
    ssp_serializer u_ssp_serializer (
        .ck_1356meg  (ck_1356meg),
        .rst_n       (rst_n),
        .sample_en   (sample_en),
        .report_load (report_load),
        .report      (report),
        .ssp_clk     (ssp_clk),
        .ssp_frame   (ssp_frame),
        .ssp_din     (ssp_din)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
/*
 * Testbench clock and reset source. 10 ns period.
 * rst_n is released 1 ns after the eighth rising edge.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
(
    output logic ck_1356meg,
    output logic rst_n
);

    localparam int half_period_ns = 5;
    localparam int reset_cycles   = 8;

    // Free-running clock.
    initial
    begin
        ck_1356meg = 1'b0;
        forever #half_period_ns ck_1356meg = ~ck_1356meg;
    end

    // Reset is released just after an edge, like any other stimulus.
    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge ck_1356meg);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/tb_hi_read_rx_xcorr.sv
/*
 * Directed testbench for the receive path. Inputs change 1 ns after each rising edge.
 * Every serial word is compared with a model that counts samples on its own.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_hi_read_rx_xcorr
    import hi_rx_pkg::*;
();

    // Windows driven by the 848, 424 and snoop tests, plus a margin.
    localparam int test_samples    = (14 + 10 + 77) * window_len;
    localparam int watchdog_ns     = test_samples * 2 * 10 + 20000;
    localparam int handshake_limit = 8;

    logic             ck_1356meg;
    logic             rst_n;
    logic [adc_w-1:0] adc_d;
    logic             cfg_req;
    logic [cfg_w-1:0] cfg_data;
    logic             cfg_ack;
    logic             carrier_on;
    logic             ssp_clk;
    logic             ssp_frame;
    logic             ssp_din;

    string cur_test = "init";

    // Reference model state.
    logic  m_848;
    logic  m_snoop;
    logic  m_phase;
    logic  pend_848;
    logic  pend_snoop;
    logic  ack_prev;
    logic  report_due;
    int    m_idx;
    int    acc_i;
    int    acc_q;
    logic  env_lvl;
    int    low_cnt;
    logic  env_mid;
    logic  env_last;
    logic [report_w-1:0] exp_q[$];

    // Serial capture state.
    logic                frame_prev;
    logic                clk_prev;
    logic                in_word;
    int                  bit_cnt;
    logic [report_w-1:0] shift_word;
    logic [report_w-1:0] last_word;
    int                  words_done;

    tb_clock_gen u_tb_clock_gen (
        .ck_1356meg (ck_1356meg),
        .rst_n      (rst_n)
    );

    hi_read_rx_xcorr u_hi_read_rx_xcorr (
        .ck_1356meg (ck_1356meg),
        .rst_n      (rst_n),
        .adc_d      (adc_d),
        .cfg_req    (cfg_req),
        .cfg_data   (cfg_data),
        .cfg_ack    (cfg_ack),
        .carrier_on (carrier_on),
        .ssp_clk    (ssp_clk),
        .ssp_frame  (ssp_frame),
        .ssp_din    (ssp_din)
    );

    // ----------------------------------------
    // Failure reporting
    // ----------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string label, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual)
        begin
            fail_run($sformatf("ERR %s %s expected %h actual %h",
                               cur_test, label, expected, actual));
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // Builds the report of a finished window from the formatting rule.
    function automatic logic [15:0] format_report();
        logic [31:0] ai;
        logic [31:0] aq;
        logic [7:0]  ib;
        logic [7:0]  qb;
        ai = acc_i;
        aq = acc_q;
        if (m_snoop)
        begin
            ib = {ai[out_msb-1:out_lsb], env_mid};
            qb = {aq[out_msb-1:out_lsb], env_last};
        end
        else
        begin
            ib = ai[out_msb:out_lsb];
            qb = aq[out_msb:out_lsb];
        end
        return {ib, qb};
    endfunction

    // One sample: correlation sums and the hysteresis detector.
    task automatic model_sample(input logic [7:0] v, input logic restart);
        int   q_idx;
        logic next_lvl;
        if (restart)
        begin
            m_idx = 0;
        end
        if (m_idx == 0)
        begin
            acc_i = 0;
            acc_q = 0;
        end
        q_idx = (m_idx + q_phase_offset) % window_len;
        if (((m_idx >> ref_half_bit) & 1) == 1)
            acc_i = acc_i - int'(v);
        else
            acc_i = acc_i + int'(v);
        if (((q_idx >> ref_half_bit) & 1) == 1)
            acc_q = acc_q - int'(v);
        else
            acc_q = acc_q + int'(v);

        // The detector bits are the level seen before this sample.
        if (m_idx == window_len / 2 - 1)
            env_mid = env_lvl;
        if (m_idx == window_len - 1)
        begin
            env_last   = env_lvl;
            report_due = 1'b1;
        end

        next_lvl = env_lvl;
        if (v == 8'hff)
            next_lvl = 1'b1;
        else if (v == 8'h00)
            next_lvl = 1'b0;
        if (env_lvl)
            low_cnt = 0;
        else if (low_cnt == hyst_timeout)
        begin
            low_cnt  = 0;
            next_lvl = 1'b1;
        end
        else
            low_cnt = low_cnt + 1;
        env_lvl = next_lvl;
        m_idx   = (m_idx + 1) % window_len;
    endtask

    // The model sees the values from before each edge.
    // A rising cfg_ack means the next edge is sample 0 of a new window.
    always @(posedge ck_1356meg)
    begin
        logic restart;
        logic take;
        if (!rst_n)
        begin
            m_848      = 1'b0;
            m_snoop    = 1'b0;
            m_phase    = 1'b1;
            ack_prev   = 1'b0;
            report_due = 1'b0;
            m_idx      = 0;
            env_lvl    = 1'b0;
            low_cnt    = 0;
        end
        else
        begin
            restart  = cfg_ack && !ack_prev;
            ack_prev = cfg_ack;
            if (restart)
            begin
                m_848   = pend_848;
                m_snoop = pend_snoop;
            end
            if (report_due)
            begin
                exp_q.push_back(format_report());
                report_due = 1'b0;
            end
            take    = restart || m_848 || m_phase;
            m_phase = restart ? 1'b0 : !m_phase;
            if (take)
                model_sample(adc_d, restart);
        end
    end

    // ----------------------------------------
    // Serial capture
    // ----------------------------------------
    // A rising frame starts a word. Data is taken where ssp_clk rises.
    always @(posedge ck_1356meg)
    begin
        if (!rst_n)
        begin
            in_word    = 1'b0;
            frame_prev = 1'b0;
            clk_prev   = 1'b0;
        end
        else
        begin
            if (ssp_frame && !frame_prev)
            begin
                in_word    = 1'b1;
                bit_cnt    = 0;
                shift_word = '0;
            end
            if (ssp_clk && !clk_prev && in_word)
            begin
                check_value("ssp_frame", 16'(bit_cnt == 0), 16'(ssp_frame));
                shift_word = {shift_word[report_w-2:0], ssp_din};
                bit_cnt    = bit_cnt + 1;
                if (bit_cnt == report_w)
                begin
                    in_word = 1'b0;
                    if (exp_q.size() == 0)
                        fail_run("A serial word arrived with no finished window to match it.");
                    check_value("ssp word", exp_q.pop_front(), shift_word);
                    last_word  = shift_word;
                    words_done = words_done + 1;
                end
            end
            frame_prev = ssp_frame;
            clk_prev   = ssp_clk;
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic drive_value(input logic [7:0] v, input int cycles);
        adc_d = v;
        repeat (cycles)
        begin
            @(posedge ck_1356meg);
            #1;
        end
    endtask

    task automatic drive_random(input int windows, input int cycles);
        repeat (windows * window_len)
            drive_value(8'($urandom_range(255, 0)), cycles);
    endtask

    // Four-phase write. Every wait is bounded.
    task automatic write_mode(input logic [cfg_w-1:0] mode);
        int waited;
        check_value("cfg_ack before req", 16'h0, 16'(cfg_ack));
        pend_848   = mode[cfg_bit_848];
        pend_snoop = mode[cfg_bit_snoop];
        cfg_data   = mode;
        cfg_req    = 1'b1;
        waited     = 0;
        while (cfg_ack !== 1'b1)
        begin
            if (waited == handshake_limit)
                fail_run("cfg_ack never rose after cfg_req went high.");
            @(posedge ck_1356meg);
            #1;
            waited = waited + 1;
        end
        cfg_req = 1'b0;
        waited  = 0;
        while (cfg_ack !== 1'b0)
        begin
            if (waited == handshake_limit)
                fail_run("cfg_ack never fell after cfg_req went low.");
            @(posedge ck_1356meg);
            #1;
            waited = waited + 1;
        end
    endtask

    task automatic expect_words(input int start, input int min_words);
        if (words_done - start < min_words)
            fail_run($sformatf("Only %0d serial words arrived in %s.",
                               words_done - start, cur_test));
    endtask

    task automatic check_idle_outputs();
        check_value("cfg_ack", 16'h0, 16'(cfg_ack));
        check_value("ssp_frame", 16'h0, 16'(ssp_frame));
        check_value("ssp_clk", 16'h0, 16'(ssp_clk));
        check_value("ssp_din", 16'h0, 16'(ssp_din));
        check_value("carrier_on", 16'h1, 16'(carrier_on));
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic run_reset_test();
        cur_test = "reset";
        repeat (3) @(posedge ck_1356meg);
        #1;
        check_idle_outputs();
        wait (rst_n === 1'b1);
        @(posedge ck_1356meg);
        #1;
        check_idle_outputs();
    endtask

    task automatic run_handshake_test();
        cur_test = "handshake";
        write_mode(2'b10);
        check_value("carrier_on", 16'h0, 16'(carrier_on));
        write_mode(2'b00);
        check_value("carrier_on", 16'h1, 16'(carrier_on));
    endtask

    // A full window that matches the I reference gives 32 * 255 on I and 0 on Q.
    task automatic run_848_test();
        int start;
        cur_test = "mode_848";
        start    = words_done;
        write_mode(2'b01);
        repeat (4 * window_len)
            drive_value(((m_idx >> ref_half_bit) & 1) == 1 ? 8'h00 : 8'hff, 1);
        check_value("reference word", {8'((32 * 255) >> out_lsb), 8'h00}, last_word);
        drive_random(8, 1);
        drive_random(2, 1);
        expect_words(start, 12);
    endtask

    task automatic run_424_test();
        int start;
        cur_test = "mode_424";
        start    = words_done;
        write_mode(2'b00);
        drive_random(8, 2);
        drive_random(2, 2);
        expect_words(start, 8);
    endtask

    task automatic run_snoop_test();
        cur_test = "snoop";
        write_mode(2'b11);
        repeat (2 * window_len) drive_value(8'hff, 1);
        repeat (4 * window_len) drive_value(8'h80, 1);
        check_value("detector bits high", 16'h0101, last_word & 16'h0101);
        repeat (window_len) drive_value(8'h00, 1);
        repeat (4 * window_len) drive_value(8'h10, 1);
        check_value("detector bits low", 16'h0000, last_word & 16'h0101);
        // Long low time. The timeout forces the level high and 0x10 holds it.
        repeat (66 * window_len) drive_value(8'h10, 1);
        check_value("detector bits forced", 16'h0101, last_word & 16'h0101);
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------
    initial
    begin
        void'($urandom(52070));
        adc_d      = '0;
        cfg_req    = 1'b0;
        cfg_data   = '0;
        pend_848   = 1'b0;
        pend_snoop = 1'b0;
        words_done = 0;
        last_word  = '0;
        run_reset_test();
        run_handshake_test();
        run_848_test();
        run_424_test();
        run_snoop_test();
        $display("test passed");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        fail_run("Timeout. The tests did not finish in the allowed time.");
    end

endmodule

`default_nettype wire

// File: filelist.f
source/hi_rx_pkg.sv
source/rx_mode_regs.sv
source/am_hysteresis.sv
source/iq_correlator.sv
source/ssp_serializer.sv
source/hi_read_rx_xcorr.sv
bench/tb_clock_gen.sv
bench/tb_hi_read_rx_xcorr.sv

// File: run_sim.sh
#!/bin/sh
# Builds the receive path testbench with Verilator and runs it.
# The exit status is the simulator's, so a $fatal fails the script.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f filelist.f \
    --top-module tb_hi_read_rx_xcorr \
    -Mdir obj_dir

./obj_dir/Vtb_hi_read_rx_xcorr
